/* block_buffer.sv */
`timescale 1ns/1ns

module block_buffer
   import pcie_pkg::*;
   import fifo_pkg::*;
#(
   parameter logic [4:0] channel = 5'd0
)
(
   input  logic         clock,
   input  logic         reset,
   input  completion_t  completion,
   input  logic         fifo_clock,
   input  buffer_addr_t read_addr,
   output data_t        read_data,
   output block_ptr_t   write_ptr
);

   data_t                 ram [slot_count * words_per_block];
   data_t                 ram_q;
   logic [slot_count-1:0] filled;          // Slot holds a complete block
   logic                  word_write;
   logic                  last_word;
   slot_t                 completion_slot;
   word_index_t           completion_index;
   buffer_addr_t          write_addr;
   slot_t                 write_slot;
   logic                  advance;

   assign word_write       = completion.valid && (completion.tag[7:3] == channel);
   assign completion_slot  = completion.tag[2:0];
   assign completion_index = completion.index;
   assign write_addr       = {completion_slot, completion_index};
   assign last_word        = word_write &&
                             (completion_index == word_index_t'(words_per_block - 1));

   assign write_slot = write_ptr[2:0];
   assign advance    = filled[write_slot];   // Release in order only

   ////////////////////
   // Write side
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (word_write)
         ram[write_addr] <= completion.data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         filled    <= '0;
         write_ptr <= '0;
      end
      else
      begin
         for (int s = 0; s < slot_count; s++)
         begin
            if (last_word && (completion_slot == slot_t'(s)))
               filled[s] <= 1'b1;
            else if (advance && (write_slot == slot_t'(s)))
               filled[s] <= 1'b0;   // Handed to the consumer
         end
         if (advance)
            write_ptr <= write_ptr + 17'd1;
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   // Two output registers, fifo_read_port delays valid to match
   always_ff @(posedge fifo_clock)
   begin
      ram_q     <= ram[read_addr];
      read_data <= ram_q;
   end

endmodule

/* dma_page_table.sv */
`timescale 1ns/1ns

module dma_page_table
   import pcie_pkg::*;
   import fifo_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  pio_write_t pio,
   input  logic [4:0] request_page,
   output page_base_t page_base,
   output block_ptr_t stop_ptr,
   output block_ptr_t int_ptr
);

   page_base_t page_ram [32];
   logic       page_write;
   logic       stop_write;
   logic       int_write;

   assign page_write = pio.valid && (pio.addr[12:5] == pio_page_table_block);
   assign stop_write = pio.valid && (pio.addr == pio_stop_addr);
   assign int_write  = pio.valid && (pio.addr == pio_int_addr);

   ////////////////////
   // Page table
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (page_write)
         page_ram[pio.addr[4:0]] <= pio.data[63:21];
      page_base <= page_ram[request_page];   // One cycle behind the request pointer
   end

   ////////////////////
   // Pointer registers
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         stop_ptr <= '0;
         int_ptr  <= '0;
      end
      else
      begin
         if (stop_write)
            stop_ptr <= pio.data[ptr_field_msb:ptr_field_lsb];
         if (int_write)
            int_ptr <= pio.data[ptr_field_msb:ptr_field_lsb];
      end
   end

endmodule

/* fifo_pkg.sv */
package fifo_pkg;

   ////////////////////
   // Block buffer geometry
   ////////////////////

   // 16:12 page, 11:0 block in page, 2:0 slot
   typedef logic [16:0] block_ptr_t;
   typedef logic [2:0]  slot_t;
   typedef logic [5:0]  word_index_t;
   typedef logic [8:0]  buffer_addr_t;   // {slot, word index}

   localparam int slot_count      = 8;
   localparam int words_per_block = 64;
   localparam int block_window    = 6;   // Blocks in flight or unread

   // Pointer field inside a PIO data word
   localparam int ptr_field_lsb = 9;
   localparam int ptr_field_msb = 25;

endpackage

/* fifo_read_port.sv */
`timescale 1ns/1ns

module fifo_read_port
   import fifo_pkg::*;
(
   input  logic         fifo_clock,
   input  logic         reset_fclk,
   input  logic         fifo_read,
   input  slot_t        write_slot_fclk,
   output buffer_addr_t read_addr,
   output logic         fifo_read_valid
);

   buffer_addr_t fill_limit;
   logic         read_ok;
   logic         read_ok_q;

   // Released data ends at the start of the write slot
   assign fill_limit = {write_slot_fclk, word_index_t'(0)};
   assign read_ok    = fifo_read && (read_addr != fill_limit);

   // Bit 6 of read_addr toggles at every block boundary
   always_ff @(posedge fifo_clock)
   begin
      if (reset_fclk)
      begin
         read_addr       <= '0;
         read_ok_q       <= 1'b0;
         fifo_read_valid <= 1'b0;
      end
      else
      begin
         if (read_ok)
            read_addr <= read_addr + 9'd1;
         read_ok_q       <= read_ok;     // RAM output register
         fifo_read_valid <= read_ok_q;   // Data register
      end
   end

endmodule

/* host_fifo_assertions.sv */
`timescale 1ns/1ns

module host_fifo_assertions
   import fifo_pkg::*;
(
   input logic         clock,
   input logic         reset,
   input logic         fifo_clock,
   input logic         reset_fclk,
   input logic         rr_valid,
   input logic         interrupt,
   input logic         fifo_read_valid,
   input block_ptr_t   request_ptr,
   input block_ptr_t   read_ptr,
   input block_ptr_t   int_ptr,
   input buffer_addr_t read_addr
);

   int clock_failures = 0;   // One count per clock domain
   int fifo_failures  = 0;

   ////////////////////
   // Request side
   ////////////////////

   reset_idle: assert property (@(posedge clock) reset |=> !rr_valid && !interrupt)
      else
      begin
         $error("rr_valid or interrupt high after reset");
         clock_failures++;
      end
   window_limit: assert property (@(posedge clock) disable iff (reset)
      (request_ptr - read_ptr) <= block_ptr_t'(block_window))
      else
      begin
         $error("more than six blocks ahead of the consumer");
         clock_failures++;
      end
   interrupt_on_match: assert property (@(posedge clock) disable iff (reset)
      $rose(read_ptr == int_ptr) |=> interrupt)
      else
      begin
         $error("no interrupt after the read pointer reached the interrupt pointer");
         clock_failures++;
      end

   ////////////////////
   // Read side
   ////////////////////

   read_then_valid: assert property (@(posedge fifo_clock) disable iff (reset_fclk)
      $changed(read_addr) |=> fifo_read_valid)
      else
      begin
         $error("fifo_read_valid missing two cycles after a read");
         fifo_failures++;
      end
   valid_needs_read: assert property (@(posedge fifo_clock) disable iff (reset_fclk)
      fifo_read_valid |-> ($past(read_addr, 2) != $past(read_addr)))
      else
      begin
         $error("fifo_read_valid without an accepted read");
         fifo_failures++;
      end

endmodule

/* host_fifo_top.sv */
`timescale 1ns/1ns

module host_fifo_top
   import pcie_pkg::*;
   import fifo_pkg::*;
#(
   parameter logic [4:0] channel = 5'd0
)
(
   input  logic        clock,
   input  logic        reset,
   input  pio_write_t  pio,
   input  completion_t completion,
   output logic        rr_valid,
   output pcie_addr_t  rr_addr,
   output tag_t        rr_tag,
   input  logic        rr_ready,
   output logic        interrupt,
   input  logic        fifo_clock,
   input  logic        fifo_read,
   output data_t       fifo_read_data,
   output logic        fifo_read_valid
);

   page_base_t   page_base;
   block_ptr_t   stop_ptr;
   block_ptr_t   int_ptr;
   block_ptr_t   request_ptr;
   block_ptr_t   read_ptr;        // Consumed blocks
   block_ptr_t   write_ptr;
   buffer_addr_t read_addr;
   slot_t        write_slot_fclk;
   logic         consumed;
   logic         reset_fclk;
   logic         read_advanced;

   dma_page_table page_table (
      .clock        (clock),
      .reset        (reset),
      .pio          (pio),
      .request_page (request_ptr[16:12]),
      .page_base    (page_base),
      .stop_ptr     (stop_ptr),
      .int_ptr      (int_ptr)
   );

   read_request_engine #(.channel(channel)) request_engine (
      .clock       (clock),
      .reset       (reset),
      .page_base   (page_base),
      .stop_ptr    (stop_ptr),
      .read_ptr    (read_ptr),
      .rr_ready    (rr_ready),
      .rr_valid    (rr_valid),
      .rr_addr     (rr_addr),
      .rr_tag      (rr_tag),
      .request_ptr (request_ptr)
   );

   block_buffer #(.channel(channel)) buffer (
      .clock      (clock),
      .reset      (reset),
      .completion (completion),
      .fifo_clock (fifo_clock),
      .read_addr  (read_addr),
      .read_data  (fifo_read_data),
      .write_ptr  (write_ptr)
   );

   pointer_cdc cdc (
      .clock           (clock),
      .fifo_clock      (fifo_clock),
      .reset           (reset),
      .write_slot      (write_ptr[2:0]),
      .read_bit        (read_addr[6]),
      .write_slot_fclk (write_slot_fclk),
      .consumed        (consumed),
      .reset_fclk      (reset_fclk)
   );

   fifo_read_port read_port (
      .fifo_clock      (fifo_clock),
      .reset_fclk      (reset_fclk),
      .fifo_read       (fifo_read),
      .write_slot_fclk (write_slot_fclk),
      .read_addr       (read_addr),
      .fifo_read_valid (fifo_read_valid)
   );

   ////////////////////
   // Read pointer and interrupt
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         read_ptr      <= '0;
         read_advanced <= 1'b0;
         interrupt     <= 1'b0;
      end
      else
      begin
         if (consumed)
            read_ptr <= read_ptr + 17'd1;
         read_advanced <= consumed;
         interrupt     <= read_advanced && (read_ptr == int_ptr);   // Only on a step
      end
   end

endmodule

/* list.f */
pcie_pkg.sv
fifo_pkg.sv
dma_page_table.sv
read_request_engine.sv
block_buffer.sv
pointer_cdc.sv
fifo_read_port.sv
host_fifo_top.sv
host_fifo_assertions.sv
tb_host_fifo.sv

/* pcie_pkg.sv */
package pcie_pkg;

   ////////////////////
   // PCIe-facing widths
   ////////////////////

   typedef logic [63:0] data_t;        // PIO, completion and FIFO word
   typedef logic [63:0] pcie_addr_t;
   typedef logic [7:0]  tag_t;         // Channel in 7:3, slot in 2:0
   typedef logic [12:0] pio_addr_t;    // Word address
   typedef logic [42:0] page_base_t;   // 2 MB aligned page base

   // PIO register map
   localparam logic [7:0] pio_page_table_block = 8'd2;   // Matched against addr 12:5
   localparam pio_addr_t  pio_stop_addr        = 13'd16;
   localparam pio_addr_t  pio_int_addr         = 13'd17;

   typedef struct packed {
      logic        valid;
      tag_t        tag;
      logic [5:0]  index;   // Word within the block
      data_t       data;
   } completion_t;

   typedef struct packed {
      logic      valid;
      pio_addr_t addr;
      data_t     data;
   } pio_write_t;

endpackage

/* pointer_cdc.sv */
`timescale 1ns/1ns

module pointer_cdc
   import fifo_pkg::*;
(
   input  logic  clock,
   input  logic  fifo_clock,
   input  logic  reset,
   input  slot_t write_slot,
   input  logic  read_bit,
   output slot_t write_slot_fclk,
   output logic  consumed,
   output logic  reset_fclk
);

   slot_t gray_q;
   slot_t gray_s1;
   slot_t gray_s2;
   logic  read_s1;
   logic  read_s2;
   logic  read_s3;
   logic  reset_s1;

   ////////////////////
   // Write slot to fifo_clock
   ////////////////////

   // Registered so only one bit moves per step
   always_ff @(posedge clock)
   begin
      if (reset)
         gray_q <= '0;
      else
         gray_q <= write_slot ^ (write_slot >> 1);
   end

   always_ff @(posedge fifo_clock)
   begin
      if (reset_fclk)
      begin
         gray_s1 <= '0;
         gray_s2 <= '0;
      end
      else
      begin
         gray_s1 <= gray_q;
         gray_s2 <= gray_s1;
      end
   end

   assign write_slot_fclk = {gray_s2[2],
                             gray_s2[2] ^ gray_s2[1],
                             gray_s2[2] ^ gray_s2[1] ^ gray_s2[0]};

   ////////////////////
   // Consumed blocks to clock
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         read_s1 <= 1'b0;
         read_s2 <= 1'b0;
         read_s3 <= 1'b0;
      end
      else
      begin
         read_s1 <= read_bit;
         read_s2 <= read_s1;
         read_s3 <= read_s2;
      end
   end

   assign consumed = read_s2 ^ read_s3;   // Either edge is one block

   // Reset into fifo_clock
   always_ff @(posedge fifo_clock)
   begin
      reset_s1   <= reset;
      reset_fclk <= reset_s1;
   end

endmodule

/* read_request_engine.sv */
`timescale 1ns/1ns

module read_request_engine
   import pcie_pkg::*;
   import fifo_pkg::*;
#(
   parameter logic [4:0] channel = 5'd0
)
(
   input  logic       clock,
   input  logic       reset,
   input  page_base_t page_base,
   input  block_ptr_t stop_ptr,
   input  block_ptr_t read_ptr,
   input  logic       rr_ready,
   output logic       rr_valid,
   output pcie_addr_t rr_addr,
   output tag_t       rr_tag,
   output block_ptr_t request_ptr
);

   slot_t request_slot;
   slot_t read_slot;
   slot_t window_edge;
   logic  window_open;
   logic  more_blocks;

   assign request_slot = request_ptr[2:0];
   assign read_slot    = read_ptr[2:0];

   // Ring holds block_window blocks ahead of the consumer
   assign window_edge = request_slot + slot_t'(slot_count - block_window);
   assign window_open = (window_edge != read_slot);
   assign more_blocks = (request_ptr != stop_ptr);

   // Level request, dropped in the accept cycle
   assign rr_valid = !rr_ready && window_open && more_blocks;

   // 512-byte block inside a 2 MB page
   assign rr_addr = {page_base, request_ptr[11:0], 9'd0};
   assign rr_tag  = {channel, request_slot};   // Completion names its slot

   always_ff @(posedge clock)
   begin
      if (reset)
         request_ptr <= '0;
      else if (rr_ready)
         request_ptr <= request_ptr + 17'd1;
   end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_host_fifo -f list.f -o tb_host_fifo
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_host_fifo +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
exit 0

/* tb_host_fifo.sv */
`timescale 1ns/1ns

module tb_host_fifo
   import pcie_pkg::*;
   import fifo_pkg::*;
();

   localparam logic [4:0] channel     = 5'd3;
   localparam int         stop_block  = 4100;   // Past 4096 so the page changes
   localparam int         int_block   = 100;
   localparam int         total_words = stop_block * words_per_block;

   logic        clock = 1'b0;
   logic        fifo_clock = 1'b0;
   logic        reset;
   pio_write_t  pio;
   completion_t completion;
   logic        rr_valid;
   pcie_addr_t  rr_addr;
   tag_t        rr_tag;
   logic        rr_ready;
   logic        interrupt;
   logic        fifo_read;
   data_t       fifo_read_data;
   logic        fifo_read_valid;

   int         seed = 32'hf082;
   page_base_t base_model [32];
   pcie_addr_t request_addr [stop_block];
   tag_t       request_tag [stop_block];
   int         request_count = 0;
   int         request_errors = 0;
   int         word_count = 0;
   int         data_errors = 0;
   int         interrupt_count = 0;
   logic       consumer_on = 1'b0;
   int         tests_run = 0;
   int         tests_failed = 0;

   always #10 clock = ~clock;
   always #7 fifo_clock = ~fifo_clock;

   host_fifo_top #(.channel(channel)) uut (
      .clock(clock), .reset(reset), .pio(pio), .completion(completion),
      .rr_valid(rr_valid), .rr_addr(rr_addr), .rr_tag(rr_tag), .rr_ready(rr_ready),
      .interrupt(interrupt), .fifo_clock(fifo_clock), .fifo_read(fifo_read),
      .fifo_read_data(fifo_read_data), .fifo_read_valid(fifo_read_valid)
   );

   bind host_fifo_top host_fifo_assertions checks (
      .clock(clock), .reset(reset), .fifo_clock(fifo_clock), .reset_fclk(reset_fclk),
      .rr_valid(rr_valid), .interrupt(interrupt), .fifo_read_valid(fifo_read_valid),
      .request_ptr(request_ptr), .read_ptr(read_ptr), .int_ptr(int_ptr),
      .read_addr(read_addr)
   );

   // Page base, block within page, 512-byte offset
   function automatic pcie_addr_t block_addr(input int block);
      block_ptr_t ptr;
      ptr = block_ptr_t'(block);
      return {base_model[ptr[16:12]], ptr[11:0], 9'd0};
   endfunction

   function automatic data_t expected_word(input int n);
      return block_addr(n / words_per_block) + data_t'(8 * (n % words_per_block));
   endfunction

   task automatic pio_write(input pio_addr_t addr, input data_t data);
      @(negedge clock);
      pio.valid = 1'b1;
      pio.addr  = addr;
      pio.data  = data;
      @(negedge clock);
      pio.valid = 1'b0;
   endtask

   task automatic send_block(input pcie_addr_t addr, input tag_t tag);
      for (int i = 0; i < words_per_block; i++)
      begin
         @(negedge clock);
         completion.valid = 1'b1;
         completion.tag   = tag;
         completion.index = 6'(i);
         completion.data  = addr + data_t'(8 * i);   // Host memory pattern
      end
   endtask

   task automatic report_test(input string name, input bit ok);
      tests_run++;
      if (!ok)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name, ok ? "passed" : "failed");
   endtask

   task automatic wait_until(input bit words, input int target, input int limit,
                             output bit expired);
      int cycles;
      cycles  = 0;
      expired = 1'b0;
      while (!expired && ((words ? word_count : request_count) < target))
      begin
         @(negedge clock);
         cycles++;
         if (cycles > limit)
         begin
            $display("timeout: %0d %s never reached", target, words ? "words" : "requests");
            expired = 1'b1;
         end
      end
   endtask

   task automatic watch_quiet(input int cycles, output bit quiet);
      quiet = 1'b1;
      repeat (cycles)
      begin
         @(negedge clock);
         if (rr_valid || interrupt || fifo_read_valid)
            quiet = 1'b0;
      end
   endtask

   ////////////////////
   // Host model
   ////////////////////

   initial
   begin : request_acceptor
      rr_ready = 1'b0;
      forever
      begin
         @(negedge clock);
         if (rr_ready)
            rr_ready = 1'b0;   // Page base catches up with the pointer
         else if (rr_valid)
         begin
            if (request_count >= stop_block)
            begin
               $display("error at %0t: request %0d past the stop pointer", $time, request_count);
               request_errors++;
            end
            else
            begin
               if (rr_addr !== block_addr(request_count) ||
                   rr_tag !== {channel, 3'(request_count)})
               begin
                  $display("error at %0t: request %0d addr %h tag %h, expected %h", $time,
                           request_count, rr_addr, rr_tag, block_addr(request_count));
                  request_errors++;
               end
               request_addr[request_count] = rr_addr;
               request_tag[request_count]  = rr_tag;
            end
            request_count++;
            rr_ready = 1'b1;
         end
      end
   end

   initial
   begin : completion_server
      int answered;
      int pending;
      answered   = 0;
      completion = '0;
      forever
      begin
         @(posedge clock);
         pending = ((request_count < stop_block) ? request_count : stop_block) - answered;
         if (pending > 0)
         begin
            repeat ($random(seed) & 7) @(posedge clock);
            pending = ((request_count < stop_block) ? request_count : stop_block) - answered;
            if (pending >= 2)
            begin
               send_block(request_addr[answered + 1], request_tag[answered + 1]);
               send_block(request_addr[answered], request_tag[answered]);
               answered += 2;
            end
            else
            begin
               send_block(request_addr[answered], request_tag[answered]);
               answered++;
            end
            @(negedge clock);
            completion.valid = 1'b0;
         end
      end
   end

   ////////////////////
   // Consumer
   ////////////////////

   initial
   begin : consumer
      fifo_read = 1'b0;
      forever
      begin
         @(negedge fifo_clock);
         fifo_read = consumer_on;
      end
   end

   always @(negedge fifo_clock)
   begin
      if (fifo_read_valid)
      begin
         if (fifo_read_data !== expected_word(word_count))
         begin
            $display("error at %0t: word %0d is %h, expected %h", $time, word_count,
                     fifo_read_data, expected_word(word_count));
            data_errors++;
         end
         word_count++;
      end
   end

   always @(negedge clock)
   begin
      if (interrupt)
         interrupt_count++;
   end

   initial
   begin : main_sequence
      bit ok;
      bit expired;
      int assert_failures;
      reset   = 1'b1;
      pio     = '0;
      expired = 1'b0;
      repeat (16) @(negedge clock);
      reset = 1'b0;

      consumer_on = 1'b1;   // Reads on an empty buffer
      watch_quiet(100, ok);
      consumer_on = 1'b0;
      report_test("idle after reset", ok && word_count == 0);

      for (int p = 0; p < 32; p++)
      begin
         base_model[p] = page_base_t'(p + 1) * 43'h1_0421 + 43'h5_0000;
         pio_write({pio_page_table_block, 5'(p)}, {base_model[p], 21'd0});
      end
      pio_write(pio_int_addr, data_t'(int_block) << ptr_field_lsb);
      pio_write(pio_stop_addr, data_t'(stop_block) << ptr_field_lsb);

      wait_until(1'b0, block_window, 2000, expired);
      if (!expired)
      begin
         watch_quiet(200, ok);
         report_test("request window", ok && request_count == block_window && word_count == 0);
         consumer_on = 1'b1;
         wait_until(1'b1, total_words, 4 * total_words, expired);
      end
      if (!expired)
      begin
         report_test("block data", data_errors == 0 && request_errors == 0);
         watch_quiet(200, ok);
         report_test("stop pointer", ok && request_count == stop_block);
         report_test("interrupt", interrupt_count == 1);
      end

      assert_failures = uut.checks.clock_failures + uut.checks.fifo_failures;
      $display("tests %0d, failed %0d, request errors %0d, data errors %0d, assertions %0d",
               tests_run, tests_failed, request_errors, data_errors, assert_failures);
      if (!expired && tests_failed == 0 && assert_failures == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
